//--- cursor_stim.txt
# R ox oy inc | I ox oy inc (extra init while busy): run, write_count rises by inc
# P x y color: probe pixel, expected colour in hex
P 2 3 80  P 6 7 80  P 0 0 80  P 15 15 80
R 2 3 32
# Outline of the 5x5 square at (2,3), corners included.
P 2 3 00  P 3 3 00  P 4 3 00  P 5 3 00
P 6 3 00  P 6 4 00  P 6 5 00  P 6 6 00
P 6 7 00  P 5 7 00  P 4 7 00  P 3 7 00
P 2 7 00  P 2 6 00  P 2 5 00  P 2 4 00
# Interior and outside.
P 4 5 80  P 3 4 80  P 7 3 80  P 2 8 80
P 1 3 80  P 2 2 80
# Square at (13,14) wraps modulo 16.
R 13 14 32
P 13 14 00  P 0 14 00  P 1 14 00  P 1 1 00
P 13 2 00  P 15 2 00  P 13 0 00  P 15 0 80
P 2 14 80  P 2 3 00  P 6 7 00  P 4 5 80
# Second init pulse during the run is ignored.
I 8 8 32
P 8 8 00  P 12 8 00  P 12 12 00  P 8 12 00
P 10 10 80

//--- sources.f
+incdir+.
cursor_pkg.sv
pixel_if.sv
cursor_sequencer.sv
pixel_fifo.sv
frame_writer.sv
cursor_top.sv
cursor_checker.sv
cursor_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root.

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --timescale 1ns/1ps \
    -f sources.f --top-module cursor_tb -o cursor_sim; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/cursor_sim)
status=$?
printf '%s\n' "$out"

if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qF '*** TEST PASSED ***'; then
  exit 0
fi
exit 1

//--- cursor_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "cursor_consts.svh"

module cursor_tb import cursor_pkg::*; ();

  logic       clk;
  logic       rst;
  logic       init;
  coord_t     origin_x;
  coord_t     origin_y;
  coord_t     rd_x;
  coord_t     rd_y;
  logic       busy;
  logic       done;
  color_t     rd_color;
  wcount_t    write_count;

  logic [7:0] kinds [$];
  int         arg_a [$];
  int         arg_b [$];
  int         arg_c [$];
  int         cycles;
  int         limit;
  int         errors;
  int         tests;
  int         failed;
  wcount_t    exp_count;

  cursor_top dut0 (
    .clk         (clk),
    .rst         (rst),
    .init        (init),
    .origin_x    (origin_x),
    .origin_y    (origin_y),
    .rd_x        (rd_x),
    .rd_y        (rd_y),
    .busy        (busy),
    .done        (done),
    .rd_color    (rd_color),
    .write_count (write_count)
  );

  always #4 clk = ~clk;

  // Run length bound, armed once the stimulus file has been counted.
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (limit > 0 && cycles >= limit) begin
      $display("Timed out after %0d cycles waiting for done", cycles);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  task automatic close_test(input string name, input int errs_before);
    begin
      tests++;
      if (errors == errs_before) begin
        $display("Test %0d %s: ok", tests, name);
      end else begin
        failed++;
        $display("Test %0d %s: failed", tests, name);
      end
    end
  endtask

  task automatic run_cursor(input int ox, input int oy, input int inc, input bit extra);
    int waited;
    int done_cycles;
    int errs_before;
    bit saw_busy;
    begin
      errs_before = errors;
      waited      = 0;
      done_cycles = 0;
      init     <= 1'b1;
      origin_x <= coord_t'(ox);
      origin_y <= coord_t'(oy);
      @(posedge clk);
      init <= 1'b0;
      @(posedge clk);
      saw_busy = busy;
      while (!done) begin
        // A second init in the middle of a run must be ignored.
        init <= extra && (waited == 4);
        @(posedge clk);
        waited++;
      end
      init <= 1'b0;
      repeat (6) begin
        if (done) begin
          done_cycles++;
        end
        @(posedge clk);
      end
      exp_count = exp_count + wcount_t'(inc);
      if (!saw_busy) begin
        $display("FAIL %0t: busy low after init at (%0d,%0d)", $time, ox, oy);
        errors++;
      end
      if (done_cycles != 1) begin
        $display("FAIL %0t: done high for %0d cycles, expected 1", $time, done_cycles);
        errors++;
      end
      if (busy) begin
        $display("FAIL %0t: busy still high after done", $time);
        errors++;
      end
      if (write_count !== exp_count) begin
        $display("FAIL %0t: write_count %0d, expected %0d", $time, write_count, exp_count);
        errors++;
      end
      close_test($sformatf("run at (%0d,%0d)", ox, oy), errs_before);
    end
  endtask

  task automatic probe_pixel(input int x, input int y, input int exp_color);
    int errs_before;
    begin
      errs_before = errors;
      rd_x <= coord_t'(x);
      rd_y <= coord_t'(y);
      @(posedge clk);
      if (rd_color !== color_t'(exp_color)) begin
        $display("FAIL %0t: pixel (%0d,%0d) read %h, expected %h",
                 $time, x, y, rd_color, color_t'(exp_color));
        errors++;
      end
      close_test($sformatf("probe (%0d,%0d)", x, y), errs_before);
    end
  endtask

  initial begin
    int fd;
    int n;
    int ch;
    int a;
    int b;
    int c;
    int runs;
    int probes;
    int errs_before;
    logic [7:0] kind;
    clk       = 1'b0;
    rst       = 1'b1;
    init      = 1'b0;
    origin_x  = '0;
    origin_y  = '0;
    rd_x      = '0;
    rd_y      = '0;
    cycles    = 0;
    limit     = 0;
    errors    = 0;
    tests     = 0;
    failed    = 0;
    exp_count = '0;
    runs      = 0;
    probes    = 0;

    // ************************************************************
    // Stimulus file
    // ************************************************************
    fd = $fopen("cursor_stim.txt", "r");
    if (fd == 0) begin
      $display("Could not open the stimulus file cursor_stim.txt");
      errors++;
    end else begin
      while (!$feof(fd)) begin
        n = $fscanf(fd, " %c", kind);
        if (n != 1) begin
          break;
        end
        if (kind == "#") begin
          ch = $fgetc(fd);
          while (ch != 10 && ch != -1) begin
            ch = $fgetc(fd);
          end
        end else begin
          if (kind == "P") begin
            n = $fscanf(fd, "%d %d %h", a, b, c);
            probes++;
          end else begin
            n = $fscanf(fd, "%d %d %d", a, b, c);
            runs++;
          end
          if (n != 3) begin
            $display("Malformed stimulus record of kind %c", kind);
            errors++;
          end
          kinds.push_back(kind);
          arg_a.push_back(a);
          arg_b.push_back(b);
          arg_c.push_back(c);
        end
      end
      $fclose(fd);
    end

    repeat (2) @(posedge clk);
    rst <= 1'b0;
    limit = runs * (2 * 36 + `HOLD_WHITE + `HOLD_BLACK + 10) + probes + 100;
    @(posedge clk);
    errs_before = errors;
    if (busy || done) begin
      $display("FAIL %0t: busy=%b done=%b after reset, expected 0", $time, busy, done);
      errors++;
    end
    if (write_count !== '0) begin
      $display("FAIL %0t: write_count %0d after reset, expected 0", $time, write_count);
      errors++;
    end
    close_test("reset state", errs_before);

    // ************************************************************
    // Records
    // ************************************************************
    for (int i = 0; i < kinds.size(); i++) begin
      case (kinds[i])
        "R": run_cursor(arg_a[i], arg_b[i], arg_c[i], 1'b0);
        "I": run_cursor(arg_a[i], arg_b[i], arg_c[i], 1'b1);
        "P": probe_pixel(arg_a[i], arg_b[i], arg_c[i]);
        default: begin
          $display("Unknown stimulus record kind %c", kinds[i]);
          errors++;
        end
      endcase
    end

    $display("Tests: %0d run, %0d failed, %0d errors", tests, failed, errors);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- cursor_checker.sv
`timescale 1ns/1ps
`default_nettype none

module cursor_checker (
  input logic clk,
  input logic rst,
  input logic busy,
  input logic done,
  input logic src_wr,
  input logic fifo_full,
  input logic fifo_empty
);

  // ************************************************************
  // Pixel path properties
  // ************************************************************

  done_pulse: assert property (@(posedge clk) disable iff (rst) done |=> !done)
    else $error("done stayed high for more than one cycle");

  // The sequencer writes at most every second cycle, so the FIFO never fills.
  no_push_full: assert property (@(posedge clk) disable iff (rst) src_wr |-> !fifo_full)
    else $error("pixel write pushed into a full FIFO");

  drained_at_done: assert property (@(posedge clk) disable iff (rst) done |-> fifo_empty)
    else $error("FIFO not empty while done is high");

  write_when_busy: assert property (@(posedge clk) disable iff (rst) src_wr |-> busy)
    else $error("pixel write issued while not busy");

endmodule

bind cursor_top cursor_checker chk0 (
  .clk        (clk),
  .rst        (rst),
  .busy       (busy),
  .done       (done),
  .src_wr     (seq_to_fifo.wr),
  .fifo_full  (fifo0.full),
  .fifo_empty (seq_to_fifo.empty)
);

`default_nettype wire

//--- cursor_top.sv
`timescale 1ns/1ps
`default_nettype none

module cursor_top import cursor_pkg::*; (
  input  logic    clk,
  input  logic    rst,
  input  logic    init,
  input  coord_t  origin_x,
  input  coord_t  origin_y,
  input  coord_t  rd_x,
  input  coord_t  rd_y,
  output logic    busy,
  output logic    done,
  output color_t  rd_color,
  output wcount_t write_count
);

  // Sequencer writes into the FIFO, the FIFO head feeds the frame writer.
  pixel_if seq_to_fifo ();
  pixel_if fifo_to_fb ();

  cursor_sequencer seq0 (
    .clk      (clk),
    .rst      (rst),
    .init     (init),
    .origin_x (origin_x),
    .origin_y (origin_y),
    .busy     (busy),
    .done     (done),
    .pix      (seq_to_fifo)
  );

  pixel_fifo fifo0 (
    .clk       (clk),
    .rst       (rst),
    .push_side (seq_to_fifo),
    .pop_side  (fifo_to_fb)
  );

  frame_writer fb0 (
    .clk         (clk),
    .rst         (rst),
    .pix         (fifo_to_fb),
    .rd_x        (rd_x),
    .rd_y        (rd_y),
    .rd_color    (rd_color),
    .write_count (write_count)
  );

endmodule

`default_nettype wire

//--- frame_writer.sv
`timescale 1ns/1ps
`default_nettype none

`include "cursor_consts.svh"

module frame_writer import cursor_pkg::*; (
  input  logic    clk,
  input  logic    rst,
  pixel_if.sink   pix,
  input  coord_t  rd_x,
  input  coord_t  rd_y,
  output color_t  rd_color,
  output wcount_t write_count
);

  localparam int CELLS  = `FRAME_DIM * `FRAME_DIM;
  localparam int ADDR_W = 2 * `COORD_W;

  color_t            mem [CELLS];
  logic [CELLS-1:0]  written;
  logic [ADDR_W-1:0] wr_addr;
  logic [ADDR_W-1:0] rd_addr;

  // Row-major addressing, y selects the row.
  assign wr_addr = {pix.y, pix.x};
  assign rd_addr = {rd_y, rd_x};

  // ************************************************************
  // Write side
  // ************************************************************

  always_ff @(posedge clk) begin
    if (pix.wr) begin
      mem[wr_addr] <= pix.color;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      written     <= '0;
      write_count <= '0;
    end else if (pix.wr) begin
      written[wr_addr] <= 1'b1;
      write_count      <= write_count + 1'b1;
    end
  end

  // ************************************************************
  // Read-back
  // ************************************************************

  // Cells never written show the background colour.
  assign rd_color = written[rd_addr] ? mem[rd_addr] : `COLOR_BG;

endmodule

`default_nettype wire

//--- pixel_fifo.sv
`timescale 1ns/1ps
`default_nettype none

`include "cursor_consts.svh"

module pixel_fifo import cursor_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  pixel_if.fifo_in  push_side,
  pixel_if.fifo_out pop_side
);

  localparam int CNT_W = `FIFO_PTR_W + 1;

  coord_t     mem_x     [`FIFO_DEPTH];
  coord_t     mem_y     [`FIFO_DEPTH];
  color_t     mem_color [`FIFO_DEPTH];
  fifo_ptr_t  wr_ptr;
  fifo_ptr_t  rd_ptr;
  logic [CNT_W-1:0] count;
  logic       empty;
  logic       full;
  logic       push;
  logic       pop;

  assign empty = (count == '0);
  assign full  = (count == CNT_W'(`FIFO_DEPTH));

  // The sink takes the head in the cycle it is valid, so every valid
  // head is popped at once.
  assign push = push_side.wr && !full;
  assign pop  = !empty;

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      mem_x[wr_ptr]     <= push_side.x;
      mem_y[wr_ptr]     <= push_side.y;
      mem_color[wr_ptr] <= push_side.color;
    end
  end

  assign push_side.empty = empty;

  assign pop_side.wr    = pop;
  assign pop_side.x     = mem_x[rd_ptr];
  assign pop_side.y     = mem_y[rd_ptr];
  assign pop_side.color = mem_color[rd_ptr];
  assign pop_side.empty = empty;

endmodule

`default_nettype wire

//--- cursor_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

`include "cursor_consts.svh"

module cursor_sequencer import cursor_pkg::*; (
  input  logic    clk,
  input  logic    rst,
  input  logic    init,
  input  coord_t  origin_x,
  input  coord_t  origin_y,
  output logic    busy,
  output logic    done,
  pixel_if.source pix
);

  localparam int STEP_W = $clog2(`SIDE_STEPS + 1);
  localparam int HOLD_MAX = (`HOLD_WHITE > `HOLD_BLACK) ? `HOLD_WHITE : `HOLD_BLACK;
  localparam int HOLD_W = $clog2(HOLD_MAX + 1);

  seq_state_t        state;
  seq_state_t        state_next;
  logic [STEP_W-1:0] step_cnt;
  logic [HOLD_W-1:0] hold_cnt;
  logic [1:0]        side;
  coord_t            org_x;
  coord_t            org_y;
  coord_t            pos_x;
  coord_t            pos_y;
  color_t            color_q;
  logic              last_step;
  logic              white_end;
  logic              black_end;
  logic              start;

  assign start     = (state == S_IDLE) && init;
  assign last_step = (step_cnt == STEP_W'(`SIDE_STEPS - 1));
  assign white_end = (hold_cnt == HOLD_W'(`HOLD_WHITE - 1));
  assign black_end = (hold_cnt == HOLD_W'(`HOLD_BLACK - 1));

  // ************************************************************
  // State transitions
  // ************************************************************

  always_comb begin
    state_next = state;
    case (state)
      S_IDLE: begin
        if (init) begin
          state_next = S_RIGHT;
        end
      end
      S_RIGHT: state_next = S_ADV_R;
      S_DOWN:  state_next = S_ADV_D;
      S_LEFT:  state_next = S_ADV_L;
      S_UP:    state_next = S_ADV_U;
      S_ADV_R: state_next = last_step ? S_SIDE_END : S_RIGHT;
      S_ADV_D: state_next = last_step ? S_SIDE_END : S_DOWN;
      S_ADV_L: state_next = last_step ? S_SIDE_END : S_LEFT;
      S_ADV_U: state_next = last_step ? S_SIDE_END : S_UP;
      S_SIDE_END: begin
        case (side)
          2'd0: state_next = S_DOWN;
          2'd1: state_next = S_LEFT;
          2'd2: state_next = S_UP;
          default: begin
            // The colour tells which pass has just closed the square.
            state_next = (color_q == `COLOR_WHITE) ? S_HOLD_WHITE : S_HOLD_BLACK;
          end
        endcase
      end
      S_HOLD_WHITE: begin
        if (white_end) begin
          state_next = S_RECOLOR;
        end
      end
      S_RECOLOR: state_next = S_RIGHT;
      S_HOLD_BLACK: begin
        // Wait for the last black pixel to leave the FIFO.
        if (black_end && pix.empty) begin
          state_next = S_DONE;
        end
      end
      S_DONE:  state_next = S_IDLE;
      default: state_next = S_IDLE;
    endcase
  end

  // ************************************************************
  // Control registers
  // ************************************************************

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= S_IDLE;
      step_cnt <= '0;
      hold_cnt <= '0;
      side     <= '0;
      color_q  <= `COLOR_WHITE;
    end else begin
      state <= state_next;
      case (state)
        S_IDLE: begin
          if (init) begin
            color_q <= `COLOR_WHITE;
          end
        end
        S_ADV_R, S_ADV_D, S_ADV_L, S_ADV_U: begin
          step_cnt <= step_cnt + 1'b1;
        end
        S_SIDE_END: begin
          step_cnt <= '0;
          side     <= side + 1'b1;
        end
        S_HOLD_WHITE: begin
          hold_cnt <= hold_cnt + 1'b1;
        end
        S_RECOLOR: begin
          hold_cnt <= '0;
          color_q  <= `COLOR_BLACK;
        end
        S_HOLD_BLACK: begin
          // Saturates here if the FIFO is still draining.
          if (!black_end) begin
            hold_cnt <= hold_cnt + 1'b1;
          end
        end
        S_DONE: begin
          hold_cnt <= '0;
        end
        default: begin
        end
      endcase
    end
  end

  // Cursor position. Coordinates wrap modulo the frame size.
  always_ff @(posedge clk) begin
    if (start) begin
      org_x <= origin_x;
      org_y <= origin_y;
      pos_x <= origin_x;
      pos_y <= origin_y;
    end else begin
      case (state)
        S_ADV_R:   pos_x <= pos_x + 1'b1;
        S_ADV_D:   pos_y <= pos_y + 1'b1;
        S_ADV_L:   pos_x <= pos_x - 1'b1;
        S_ADV_U:   pos_y <= pos_y - 1'b1;
        S_RECOLOR: begin
          pos_x <= org_x;
          pos_y <= org_y;
        end
        default: begin
        end
      endcase
    end
  end

  // ************************************************************
  // Outputs
  // ************************************************************

  assign pix.wr    = (state == S_RIGHT) || (state == S_DOWN) ||
                     (state == S_LEFT) || (state == S_UP);
  assign pix.x     = pos_x;
  assign pix.y     = pos_y;
  assign pix.color = color_q;

  assign busy = (state != S_IDLE);
  assign done = (state == S_DONE);

endmodule

`default_nettype wire

//--- pixel_if.sv
`timescale 1ns/1ps
`default_nettype none

// One pixel write per cycle that wr is high. On the FIFO output side wr
// marks a valid head entry.
interface pixel_if import cursor_pkg::*; ();

  logic   wr;
  coord_t x;
  coord_t y;
  color_t color;
  logic   empty;

  modport source (
    output wr, x, y, color,
    input  empty
  );

  modport fifo_in (
    input  wr, x, y, color,
    output empty
  );

  modport fifo_out (
    output wr, x, y, color, empty
  );

  modport sink (
    input wr, x, y, color
  );

endinterface

`default_nettype wire

//--- cursor_pkg.sv
`default_nettype none

`include "cursor_consts.svh"

package cursor_pkg;

  typedef logic [`COORD_W-1:0] coord_t;
  typedef logic [`COLOR_W-1:0] color_t;
  typedef logic [`FIFO_PTR_W-1:0] fifo_ptr_t;
  typedef logic [`WCOUNT_W-1:0] wcount_t;

  // Paint states issue a write, advance states move the cursor.
  typedef enum logic [4:0] {
    S_IDLE,
    S_RIGHT,
    S_DOWN,
    S_LEFT,
    S_UP,
    S_ADV_R,
    S_ADV_D,
    S_ADV_L,
    S_ADV_U,
    S_SIDE_END,
    S_HOLD_WHITE,
    S_RECOLOR,
    S_HOLD_BLACK,
    S_DONE
  } seq_state_t;

endpackage

`default_nettype wire

//--- cursor_consts.svh
`ifndef CURSOR_CONSTS_SVH
`define CURSOR_CONSTS_SVH

// Frame geometry. FRAME_DIM must equal 2**COORD_W so coordinates wrap.
`define FRAME_DIM 16
`define COORD_W 4
`define COLOR_W 8

// Cursor path and hold times in clock cycles.
`define SIDE_STEPS 4
`define HOLD_WHITE 6
// Must be at least 4 so the FIFO has drained before done.
`define HOLD_BLACK 6

// Pixel colours.
`define COLOR_WHITE 8'hFF
`define COLOR_BLACK 8'h00
// Read back for pixels that were never written.
`define COLOR_BG 8'h80

// Pixel write FIFO.
`define FIFO_DEPTH 4
`define FIFO_PTR_W 2

// Width of the pixel write counter.
`define WCOUNT_W 8

`endif
